//--- hw/sb_cfg_pkg.sv
/*
 * Store buffer configuration
 * Sizing constants and the base vector types of the datapath
 */
`default_nettype none

package sb_cfg_pkg;

  // ----------------------------------------------------------
  // Buffer and datapath sizes
  // ----------------------------------------------------------
  localparam int unsigned SB_DEPTH  = 4;                 // Four entries
  localparam int unsigned SB_IDX_W  = $clog2(SB_DEPTH);
  localparam int unsigned XLEN      = 64;
  localparam int unsigned ROB_IDX_W = 4;
  localparam int unsigned BE_W      = XLEN / 8;          // One enable per byte lane

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  typedef logic [SB_IDX_W-1:0]  sb_idx_t;   // Entry index, doubles as memory tag
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Memory byte enable
  typedef logic [BE_W-1:0] be_t;

endpackage

`default_nettype wire

//--- hw/sb_types_pkg.sv
/*
 * Store buffer types
 * Width and state encodings, plus the structs passed between blocks
 */
`default_nettype none

package sb_types_pkg;

  // Load/store access width
  typedef enum logic [2:0] {
    LS_BYTE,
    LS_BYTE_U,
    LS_HALFWORD,
    LS_HALFWORD_U,
    LS_WORD,
    LS_WORD_U,
    LS_DOUBLEWORD
  } ls_width_t;

  // Per-entry FSM
  typedef enum logic [3:0] {
    SB_EMPTY,
    SB_RS12_PENDING,   // Waiting for both operands
    SB_RS1_PENDING,
    SB_RS2_PENDING,
    SB_ADDR_REQ,
    SB_ADDR_WAIT,
    SB_WAIT_COMMIT,
    SB_MEM_REQ,
    SB_MEM_WAIT,
    SB_COMPLETED
  } sb_state_t;

  // Operand from issue, value valid only when ready is set
  typedef struct packed {
    logic                 ready;
    sb_cfg_pkg::rob_idx_t rob_idx;
    sb_cfg_pkg::xlen_t    value;
  } op_data_t;

  typedef struct packed {
    sb_cfg_pkg::rob_idx_t rob_idx;
    sb_cfg_pkg::xlen_t    res_value;
  } cdb_data_t;

  typedef struct packed {
    sb_cfg_pkg::sb_idx_t tag;
    sb_cfg_pkg::xlen_t   base;
    sb_cfg_pkg::xlen_t   offs;
    ls_width_t           width;
  } adder_req_t;

  typedef struct packed {
    sb_cfg_pkg::sb_idx_t tag;
    sb_cfg_pkg::xlen_t   result;
  } adder_ans_t;

  // Contents of one buffer entry
  typedef struct packed {
    ls_width_t            width;
    sb_cfg_pkg::rob_idx_t rs1_rob_idx;
    sb_cfg_pkg::xlen_t    rs1_value;
    sb_cfg_pkg::rob_idx_t rs2_rob_idx;
    sb_cfg_pkg::xlen_t    rs2_value;
    sb_cfg_pkg::rob_idx_t dest_rob_idx;
    sb_cfg_pkg::xlen_t    imm_addr;      // Offset first, address once the adder answers
  } sb_data_t;

endpackage

`default_nettype wire

//--- hw/sb_pointers.sv
/*
 * Store buffer pointers
 * Five wrapping queue indices, each stepped by its own strobe
 */
`default_nettype none

module sb_pointers (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          flush_i,

  input  wire logic          push_i,
  input  wire logic          pop_i,
  input  wire logic          addr_issued_i,
  input  wire logic          clear_i,
  input  wire logic          mem_issued_i,

  output sb_cfg_pkg::sb_idx_t head_o,    // Oldest store, next to retire
  output sb_cfg_pkg::sb_idx_t tail_o,    // Next free slot
  output sb_cfg_pkg::sb_idx_t addr_o,    // Next store needing an address
  output sb_cfg_pkg::sb_idx_t clear_o,   // Next store awaiting commit
  output sb_cfg_pkg::sb_idx_t mem_o      // Next store to write memory
);

  import sb_cfg_pkg::*;

  sb_idx_t head_q, tail_q, addr_q, clear_q, mem_q;

  // Step modulo the buffer depth
  function automatic sb_idx_t ptr_inc(sb_idx_t ptr);
    if (ptr == sb_idx_t'(SB_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptrs
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      addr_q  <= '0;
      clear_q <= '0;
      mem_q   <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      addr_q  <= '0;
      clear_q <= '0;
      mem_q   <= '0;
    end else begin
      if (pop_i)         head_q  <= ptr_inc(head_q);
      if (push_i)        tail_q  <= ptr_inc(tail_q);
      if (addr_issued_i) addr_q  <= ptr_inc(addr_q);
      if (clear_i)       clear_q <= ptr_inc(clear_q);
      if (mem_issued_i)  mem_q   <= ptr_inc(mem_q);
    end
  end

  assign head_o  = head_q;
  assign tail_o  = tail_q;
  assign addr_o  = addr_q;
  assign clear_o = clear_q;
  assign mem_o   = mem_q;

endmodule

`default_nettype wire

//--- hw/sb_entry.sv
/*
 * Store buffer entry
 * Tracks one store from issue to retirement and holds its operands
 */
`default_nettype none

module sb_entry (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    flush_i,

  // Issue, already qualified by the tail index
  input  wire logic                    push_i,
  input  wire sb_types_pkg::op_data_t  issue_rs1_i,
  input  wire sb_types_pkg::op_data_t  issue_rs2_i,
  input  wire sb_cfg_pkg::xlen_t       issue_imm_i,
  input  wire sb_types_pkg::ls_width_t issue_width_i,
  input  wire sb_cfg_pkg::rob_idx_t    issue_rob_idx_i,

  // CDB snoop
  input  wire logic                    cdb_valid_i,
  input  wire sb_types_pkg::cdb_data_t cdb_data_i,

  // Address adder
  input  wire logic                    addr_issued_i,
  input  wire logic                    addr_done_i,
  input  wire sb_cfg_pkg::xlen_t       addr_i,

  // Commit, memory and retire
  input  wire logic                    clear_i,
  input  wire logic                    mem_issued_i,
  input  wire logic                    mem_done_i,
  input  wire logic                    pop_i,

  output sb_types_pkg::sb_state_t      state_o,
  output sb_types_pkg::sb_data_t       data_o
);

  import sb_types_pkg::*;

  sb_state_t state_q, state_d;
  sb_data_t  data_q;
  logic      rs1_wait, rs2_wait;
  logic      cap_rs1, cap_rs2;

  assign rs1_wait = (state_q == SB_RS12_PENDING) || (state_q == SB_RS1_PENDING);
  assign rs2_wait = (state_q == SB_RS12_PENDING) || (state_q == SB_RS2_PENDING);

  // Grab a broadcast result whose tag matches a missing operand
  assign cap_rs1 = cdb_valid_i & rs1_wait & (cdb_data_i.rob_idx == data_q.rs1_rob_idx);
  assign cap_rs2 = cdb_valid_i & rs2_wait & (cdb_data_i.rob_idx == data_q.rs2_rob_idx);

  // ----------------------------------------------------------
  // Entry FSM
  // ----------------------------------------------------------
  always_comb begin : p_next_state
    state_d = state_q;
    unique case (state_q)
      SB_EMPTY: begin
        if (push_i) begin
          unique case ({issue_rs1_i.ready, issue_rs2_i.ready})
            2'b11:   state_d = SB_ADDR_REQ;
            2'b01:   state_d = SB_RS1_PENDING;
            2'b10:   state_d = SB_RS2_PENDING;
            default: state_d = SB_RS12_PENDING;
          endcase
        end
      end
      SB_RS12_PENDING: begin
        if (cap_rs1 && cap_rs2) begin
          state_d = SB_ADDR_REQ;     // Same producer for both
        end else if (cap_rs1) begin
          state_d = SB_RS2_PENDING;
        end else if (cap_rs2) begin
          state_d = SB_RS1_PENDING;
        end
      end
      SB_RS1_PENDING: begin
        if (cap_rs1) state_d = SB_ADDR_REQ;
      end
      SB_RS2_PENDING: begin
        if (cap_rs2) state_d = SB_ADDR_REQ;
      end
      SB_ADDR_REQ, SB_ADDR_WAIT: begin
        if (addr_done_i) begin
          // Commit may clear the store in the same cycle the address lands
          state_d = clear_i ? SB_MEM_REQ : SB_WAIT_COMMIT;
        end else if (state_q == SB_ADDR_REQ && addr_issued_i) begin
          state_d = SB_ADDR_WAIT;
        end
      end
      SB_WAIT_COMMIT: begin
        if (clear_i) state_d = SB_MEM_REQ;
      end
      SB_MEM_REQ, SB_MEM_WAIT: begin
        if (mem_done_i) begin
          state_d = SB_COMPLETED;
        end else if (state_q == SB_MEM_REQ && mem_issued_i) begin
          state_d = SB_MEM_WAIT;
        end
      end
      SB_COMPLETED: begin
        if (pop_i) state_d = SB_EMPTY;
      end
      default: state_d = SB_EMPTY;   // Unused codes fall back to empty
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= SB_EMPTY;
    end else if (flush_i) begin
      state_q <= SB_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin : p_data
    if (push_i) begin
      data_q.width        <= issue_width_i;
      data_q.rs1_rob_idx  <= issue_rs1_i.rob_idx;
      data_q.rs1_value    <= issue_rs1_i.value;
      data_q.rs2_rob_idx  <= issue_rs2_i.rob_idx;
      data_q.rs2_value    <= issue_rs2_i.value;
      data_q.dest_rob_idx <= issue_rob_idx_i;
      data_q.imm_addr     <= issue_imm_i;
    end else begin
      if (cap_rs1) data_q.rs1_value <= cdb_data_i.res_value;
      if (cap_rs2) data_q.rs2_value <= cdb_data_i.res_value;
      if (addr_done_i) data_q.imm_addr <= addr_i;   // Offset replaced by address
    end
  end

  assign state_o = state_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- hw/sb_mem_port.sv
/*
 * Store buffer memory port
 * Builds the write request and byte enable for the selected entry
 */
`default_nettype none

module sb_mem_port (
  input  wire sb_types_pkg::sb_data_t  entry_i,
  input  wire sb_types_pkg::sb_state_t state_i,

  output logic                         mem_valid_o,
  output sb_cfg_pkg::xlen_t            mem_addr_o,
  output sb_cfg_pkg::xlen_t            mem_wdata_o,
  output sb_cfg_pkg::be_t              mem_be_o
);

  import sb_types_pkg::*;

  // Request only once the store is committed
  assign mem_valid_o = (state_i == SB_MEM_REQ);
  assign mem_addr_o  = entry_i.imm_addr;
  assign mem_wdata_o = entry_i.rs2_value;

  // ----------------------------------------------------------
  // Byte enable from access width
  // ----------------------------------------------------------
  always_comb begin : p_byte_en
    unique case (entry_i.width)
      LS_BYTE, LS_BYTE_U: begin
        mem_be_o = 8'b0000_0001;
      end
      LS_HALFWORD, LS_HALFWORD_U: begin
        mem_be_o = 8'b0000_0011;
      end
      LS_WORD, LS_WORD_U: begin
        mem_be_o = 8'b0000_1111;
      end
      LS_DOUBLEWORD: begin
        mem_be_o = 8'b1111_1111;
      end
      default: begin
        mem_be_o = 8'b0000_0000;   // Illegal width writes nothing
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/store_buffer.sv
/*
 * Store buffer
 * In-order queue of stores between issue, address adder, commit and memory
 */
`default_nettype none

module store_buffer (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,

  // Issue stage
  input  wire logic                     issue_valid_i,
  output logic                          issue_ready_o,
  input  wire sb_types_pkg::op_data_t   issue_rs1_i,       // Base address
  input  wire sb_types_pkg::op_data_t   issue_rs2_i,       // Data to store
  input  wire sb_cfg_pkg::xlen_t        issue_imm_i,       // Address offset
  input  wire sb_types_pkg::ls_width_t  issue_width_i,
  input  wire sb_cfg_pkg::rob_idx_t     issue_rob_idx_i,

  // Common data bus
  input  wire logic                     cdb_valid_i,
  input  wire sb_types_pkg::cdb_data_t  cdb_data_i,
  output logic                          cdb_valid_o,
  input  wire logic                     cdb_ready_i,
  output sb_types_pkg::cdb_data_t       cdb_data_o,

  // Address adder
  output logic                          adder_valid_o,
  input  wire logic                     adder_ready_i,
  output sb_types_pkg::adder_req_t      adder_req_o,
  input  wire logic                     adder_valid_i,
  input  wire sb_types_pkg::adder_ans_t adder_ans_i,

  // Commit stage
  input  wire logic                     comm_clear_i,
  output sb_cfg_pkg::rob_idx_t          comm_rob_idx_o,

  // Memory
  output logic                          mem_valid_o,
  input  wire logic                     mem_ready_i,
  output sb_cfg_pkg::xlen_t             mem_addr_o,
  output sb_cfg_pkg::xlen_t             mem_wdata_o,
  output sb_cfg_pkg::be_t               mem_be_o,
  output sb_cfg_pkg::sb_idx_t           mem_tag_o,
  input  wire logic                     mem_valid_i,
  input  wire sb_cfg_pkg::sb_idx_t      mem_tag_i
);

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  sb_idx_t   head_idx, tail_idx, addr_idx, clear_idx, mem_idx;
  sb_state_t state [SB_DEPTH];
  sb_data_t  data  [SB_DEPTH];
  logic      push, pop, addr_issued, clear, mem_issued;
  logic      clear_on_addr;   // Entry under clear check gets its address now

  // ----------------------------------------------------------
  // Handshake strobes
  // ----------------------------------------------------------
  assign push          = issue_valid_i & issue_ready_o;
  assign pop           = cdb_valid_o & cdb_ready_i;
  assign addr_issued   = adder_valid_o & adder_ready_i;
  assign mem_issued    = mem_valid_o & mem_ready_i;
  assign clear_on_addr = adder_valid_i & (adder_ans_i.tag == clear_idx);
  assign clear = comm_clear_i & ((state[clear_idx] == SB_WAIT_COMMIT) | clear_on_addr);

  sb_pointers u_pointers (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .push_i       (push),
    .pop_i        (pop),
    .addr_issued_i(addr_issued),
    .clear_i      (clear),
    .mem_issued_i (mem_issued),
    .head_o       (head_idx),
    .tail_o       (tail_idx),
    .addr_o       (addr_idx),
    .clear_o      (clear_idx),
    .mem_o        (mem_idx)
  );

  // Each strobe reaches only the entry its pointer or tag names
  for (genvar i = 0; i < SB_DEPTH; i++) begin : gen_entry
    sb_entry u_entry (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .flush_i        (flush_i),
      .push_i         (push & (tail_idx == sb_idx_t'(i))),
      .issue_rs1_i    (issue_rs1_i),
      .issue_rs2_i    (issue_rs2_i),
      .issue_imm_i    (issue_imm_i),
      .issue_width_i  (issue_width_i),
      .issue_rob_idx_i(issue_rob_idx_i),
      .cdb_valid_i    (cdb_valid_i),
      .cdb_data_i     (cdb_data_i),
      .addr_issued_i  (addr_issued & (addr_idx == sb_idx_t'(i))),
      .addr_done_i    (adder_valid_i & (adder_ans_i.tag == sb_idx_t'(i))),
      .addr_i         (adder_ans_i.result),
      .clear_i        (clear & (clear_idx == sb_idx_t'(i))),
      .mem_issued_i   (mem_issued & (mem_idx == sb_idx_t'(i))),
      .mem_done_i     (mem_valid_i & (mem_tag_i == sb_idx_t'(i))),
      .pop_i          (pop & (head_idx == sb_idx_t'(i))),
      .state_o        (state[i]),
      .data_o         (data[i])
    );
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  assign issue_ready_o  = (state[tail_idx] == SB_EMPTY);
  assign comm_rob_idx_o = data[clear_idx].dest_rob_idx;

  // Retire with the store address in the result field
  assign cdb_valid_o          = (state[head_idx] == SB_COMPLETED);
  assign cdb_data_o.rob_idx   = data[head_idx].dest_rob_idx;
  assign cdb_data_o.res_value = data[head_idx].imm_addr;

  assign adder_valid_o     = (state[addr_idx] == SB_ADDR_REQ);
  assign adder_req_o.tag   = addr_idx;
  assign adder_req_o.base  = data[addr_idx].rs1_value;
  assign adder_req_o.offs  = data[addr_idx].imm_addr;
  assign adder_req_o.width = data[addr_idx].width;

  sb_mem_port u_mem_port (
    .entry_i    (data[mem_idx]),
    .state_i    (state[mem_idx]),
    .mem_valid_o(mem_valid_o),
    .mem_addr_o (mem_addr_o),
    .mem_wdata_o(mem_wdata_o),
    .mem_be_o   (mem_be_o)
  );

  assign mem_tag_o = mem_idx;   // Response comes back with the entry index

endmodule

`default_nettype wire

//--- sim/tb_store_buffer.sv
/*
 * Store buffer testbench
 * Runs stores from a case file past models of the adder, memory, commit and CDB
 */
`default_nettype none

module tb_store_buffer;
  timeunit 1ns;
  timeprecision 1ps;

  import sb_cfg_pkg::*;
  import sb_types_pkg::*;

  localparam int N_CASES    = 8;
  localparam int N_FIELDS   = 9;
  localparam int N_PUSHES   = N_CASES + 4 + 3 + 4;   // Stream, full, flush, after flush
  localparam int MAX_CYCLES = 200 * N_PUSHES;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  logic       flush = 1'b0;
  logic       issue_valid = 1'b0;
  logic       issue_ready;
  op_data_t   issue_rs1 = '0;
  op_data_t   issue_rs2 = '0;
  xlen_t      issue_imm = '0;
  ls_width_t  issue_width = LS_BYTE;
  rob_idx_t   issue_rob_idx = '0;
  logic       cdb_valid_in = 1'b0;
  cdb_data_t  cdb_data_in = '0;
  logic       cdb_valid_out;
  logic       cdb_ready = 1'b0;
  cdb_data_t  cdb_data_out;
  logic       adder_valid_out;
  logic       adder_ready = 1'b0;
  adder_req_t adder_req;
  logic       adder_valid_in = 1'b0;
  adder_ans_t adder_ans = '0;
  logic       comm_clear = 1'b1;    // Commit clears every store at once
  rob_idx_t   comm_rob_idx;
  logic       mem_valid_out;
  logic       mem_ready = 1'b0;
  xlen_t      mem_addr, mem_wdata;
  be_t        mem_be;
  sb_idx_t    mem_tag_out;
  logic       mem_valid_in = 1'b0;
  sb_idx_t    mem_tag_in = '0;

  logic [63:0] cases_mem [N_CASES*N_FIELDS];
  integer      seed = 97;
  int          cyc = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          pop_cnt = 0;
  logic        adder_en = 1'b1;

  adder_ans_t adder_pipe [$];
  int         adder_due [$];
  sb_idx_t    mem_pipe [$];
  int         mem_due [$];
  logic [2:0] exp_add_width [$];
  rob_idx_t   exp_commit_rob [$];
  xlen_t      exp_mem_addr [$];
  xlen_t      exp_mem_data [$];
  be_t        exp_mem_be [$];
  rob_idx_t   exp_ret_rob [$];
  xlen_t      exp_ret_addr [$];

  store_buffer u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_i        (flush),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .issue_rs1_i    (issue_rs1),
    .issue_rs2_i    (issue_rs2),
    .issue_imm_i    (issue_imm),
    .issue_width_i  (issue_width),
    .issue_rob_idx_i(issue_rob_idx),
    .cdb_valid_i    (cdb_valid_in),
    .cdb_data_i     (cdb_data_in),
    .cdb_valid_o    (cdb_valid_out),
    .cdb_ready_i    (cdb_ready),
    .cdb_data_o     (cdb_data_out),
    .adder_valid_o  (adder_valid_out),
    .adder_ready_i  (adder_ready),
    .adder_req_o    (adder_req),
    .adder_valid_i  (adder_valid_in),
    .adder_ans_i    (adder_ans),
    .comm_clear_i   (comm_clear),
    .comm_rob_idx_o (comm_rob_idx),
    .mem_valid_o    (mem_valid_out),
    .mem_ready_i    (mem_ready),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_be_o       (mem_be),
    .mem_tag_o      (mem_tag_out),
    .mem_valid_i    (mem_valid_in),
    .mem_tag_i      (mem_tag_in)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cyc = cyc + 1;
    if (cyc > MAX_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Checks and expected values
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Low byte lanes per access size
  function automatic be_t be_for_width(input logic [2:0] code);
    case (code)
      3'd0, 3'd1: return 8'h01;
      3'd2, 3'd3: return 8'h03;
      3'd4, 3'd5: return 8'h0f;
      default:    return 8'hff;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Models of the surrounding blocks
  // ------------------------------------------------------------
  always @(negedge clk) begin : adder_model
    adder_valid_in = 1'b0;
    if (adder_due.size() != 0 && adder_due[0] == cyc) begin
      adder_valid_in = 1'b1;
      adder_ans = adder_pipe.pop_front();
      void'(adder_due.pop_front());
      // Commit clears the store as its address lands
      if (exp_commit_rob.size() != 0) begin
        check_value("comm_rob_idx_o", 64'(comm_rob_idx), 64'(exp_commit_rob.pop_front()));
      end
    end
    adder_ready = adder_en && (($random(seed) & 1) != 0);
    if (adder_valid_out && adder_ready) begin   // Transfer on the coming edge
      if (exp_add_width.size() == 0) begin
        $display("unexpected adder request at %0t ns for entry %0d", $time, adder_req.tag);
        errors++;
      end else begin
        check_value("adder_req_o.width", 64'(adder_req.width),
                    64'(exp_add_width.pop_front()));
      end
      adder_pipe.push_back('{tag: adder_req.tag, result: adder_req.base + adder_req.offs});
      adder_due.push_back(cyc + 2);
    end
  end

  always @(negedge clk) begin : mem_model
    mem_valid_in = 1'b0;
    if (mem_due.size() != 0 && mem_due[0] == cyc) begin
      mem_valid_in = 1'b1;
      mem_tag_in = mem_pipe.pop_front();
      void'(mem_due.pop_front());
    end
    mem_ready = (($random(seed) & 1) != 0);
    if (mem_valid_out && mem_ready) begin
      if (exp_mem_addr.size() == 0) begin
        $display("unexpected memory write at %0t ns to address %h", $time, mem_addr);
        errors++;
      end else begin
        check_value("mem_addr_o", mem_addr, exp_mem_addr.pop_front());
        check_value("mem_wdata_o", mem_wdata, exp_mem_data.pop_front());
        check_value("mem_be_o", 64'(mem_be), 64'(exp_mem_be.pop_front()));
      end
      mem_pipe.push_back(mem_tag_out);
      mem_due.push_back(cyc + 3);
    end
  end

  always @(negedge clk) begin : cdb_consumer
    cdb_ready = (($random(seed) & 1) != 0);
    if (cdb_valid_out && cdb_ready) begin
      pop_cnt++;
      if (exp_ret_rob.size() == 0) begin
        $display("unexpected store retired at %0t ns, ROB tag %h", $time, cdb_data_out.rob_idx);
        errors++;
      end else begin
        check_value("cdb_data_o.rob_idx", 64'(cdb_data_out.rob_idx),
                    64'(exp_ret_rob.pop_front()));
        check_value("cdb_data_o.res_value", cdb_data_out.res_value, exp_ret_addr.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic broadcast(input rob_idx_t tag, input xlen_t value);
    cdb_valid_in = 1'b1;
    cdb_data_in  = '{rob_idx: tag, res_value: value};
    @(negedge clk);
    cdb_valid_in = 1'b0;
  endtask

  // Called on a falling edge, returns on one
  task automatic issue_case(input int idx, input bit track);
    int    b;
    xlen_t rs1_v, rs2_v, imm;
    logic  rs1_rdy, rs2_rdy;
    b       = idx * N_FIELDS;
    rs1_v   = cases_mem[b];
    rs1_rdy = cases_mem[b+1][0];
    rs2_v   = cases_mem[b+2];
    rs2_rdy = cases_mem[b+3][0];
    imm     = cases_mem[b+4];
    issue_valid   = 1'b1;
    issue_rs1     = '{ready: rs1_rdy, rob_idx: cases_mem[b+7][3:0], value: rs1_rdy ? rs1_v : '0};
    issue_rs2     = '{ready: rs2_rdy, rob_idx: cases_mem[b+8][3:0], value: rs2_rdy ? rs2_v : '0};
    issue_imm     = imm;
    issue_width   = ls_width_t'(cases_mem[b+5][2:0]);
    issue_rob_idx = cases_mem[b+6][3:0];
    while (!issue_ready) @(negedge clk);
    // Push lands on the coming edge
    if (track) begin
      exp_add_width.push_back(cases_mem[b+5][2:0]);
      exp_commit_rob.push_back(cases_mem[b+6][3:0]);
      exp_mem_addr.push_back(rs1_v + imm);
      exp_mem_data.push_back(rs2_v);
      exp_mem_be.push_back(be_for_width(cases_mem[b+5][2:0]));
      exp_ret_rob.push_back(cases_mem[b+6][3:0]);
      exp_ret_addr.push_back(rs1_v + imm);
    end
    @(negedge clk);
    issue_valid = 1'b0;
    if (!rs1_rdy) broadcast(cases_mem[b+7][3:0], rs1_v);
    if (!rs2_rdy) broadcast(cases_mem[b+8][3:0], rs2_v);
  endtask

  task automatic wait_drain();
    while (exp_ret_rob.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  initial begin : main
    int start;
    int pops;
    $readmemh("sim/sb_cases.txt", cases_mem);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // All stores in file order, operands partly over the CDB
    start = errors;
    for (int i = 0; i < N_CASES; i++) begin
      issue_case(i, 1'b1);
    end
    wait_drain();
    finish_test("stream", start);

    // Four stores stuck before the adder fill the buffer
    start = errors;
    adder_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue_case(i, 1'b1);
    end
    repeat (10) begin
      @(negedge clk);
      if (issue_ready) begin
        $display("issue_ready_o is high at %0t ns with the buffer full", $time);
        errors++;
      end
    end
    pops = pop_cnt;
    adder_en = 1'b1;
    while (!issue_ready) @(negedge clk);
    if (pop_cnt == pops) begin
      $display("issue_ready_o rose at %0t ns before any store retired", $time);
      errors++;
    end
    wait_drain();
    finish_test("full", start);

    // Flush with stores waiting, then normal traffic again
    start = errors;
    adder_en = 1'b0;
    for (int i = 4; i < 7; i++) begin
      issue_case(i, 1'b0);
    end
    flush = 1'b1;
    adder_pipe.delete();
    adder_due.delete();
    mem_pipe.delete();
    mem_due.delete();
    @(negedge clk);
    flush = 1'b0;
    if (adder_valid_out || mem_valid_out || cdb_valid_out || !issue_ready) begin
      $display("buffer not idle at %0t ns after flush", $time);
      errors++;
    end
    adder_en = 1'b1;
    for (int i = 4; i < N_CASES; i++) begin
      issue_case(i, 1'b1);
    end
    wait_drain();
    finish_test("flush", start);

    $display("tests passed %0d, failed %0d, failed checks %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/sb_cfg_pkg.sv
hw/sb_types_pkg.sv
hw/sb_pointers.sv
hw/sb_entry.sv
hw/sb_mem_port.sv
hw/store_buffer.sv
sim/tb_store_buffer.sv

//--- Bender.yml
package:
  name: store_buffer

sources:
  - files:
      - hw/sb_cfg_pkg.sv
      - hw/sb_types_pkg.sv
      - hw/sb_pointers.sv
      - hw/sb_entry.sv
      - hw/sb_mem_port.sv
      - hw/store_buffer.sv
  - target: test
    files:
      - sim/tb_store_buffer.sv

//--- sim/sb_cases.txt
// rs1_value rs1_ready rs2_value rs2_ready imm width dest_rob rs1_tag rs2_tag
// Pending operands (ready 0) arrive on the CDB under their tag after issue
0000000000001000 1 1122334455667788 1 0000000000000010 0 1 0 0
0000000000002000 0 00000000cafef00d 1 0000000000000008 2 2 5 0
0000000000003000 1 0123456789abcdef 0 0000000000000020 4 3 0 6
0000000080000000 0 deadbeefdeadbeef 0 0000000000000100 6 4 7 8
0000000000004400 1 00000000000000a5 1 0000000000000001 1 5 0 0
0000000000005000 0 000000000000beef 1 0000000000000002 3 6 9 0
0000000000006000 1 0000000012345678 0 0000000000000004 5 7 0 a
0000000000008000 1 0f0e0d0c0b0a0908 1 fffffffffffffff8 6 8 0 0
